//--- rtl/eth_tx_pkg.sv
// constants and types shared by the GMII transmit path
// imported by the FIFO, the CRC block and the framer
package eth_tx_pkg;

    // preamble and start delimiter bytes
    localparam logic [7:0] eth_pre = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    localparam int preamble_len = 7;

    // minimum frame size with FCS, payload padded to min_frame_len - 4
    localparam int min_frame_len = 64;

    // CRC-32, normal form; the CRC block reflects it
    localparam logic [31:0] crc_poly = 32'h04C11DB7;
    localparam logic [31:0] crc_init = 32'hFFFFFFFF;

    // 512 byte frame store, a frame must fit in it whole
    localparam int fifo_addr_w = 9;

    // framer byte counter width
    localparam int ptr_w = 16;

    typedef enum logic [2:0] {
        state_idle,
        state_preamble,
        state_payload,
        state_last,
        state_pad,
        state_fcs,
        state_ifg
    } framer_state_t;

endpackage

//--- rtl/byte_stream_if.sv
// byte-wide valid/ready stream with last and user flags
// src drives the payload, dst drives ready
interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;
    // user on the last byte marks a bad frame
    logic       user;

    modport src (
        output data, valid, last, user,
        input  ready
    );

    modport dst (
        input  data, valid, last, user,
        output ready
    );

endinterface

//--- rtl/eth_crc32_byte.sv
// one byte step of the reflected Ethernet CRC-32
// purely combinational, the caller holds the running state
module eth_crc32_byte
    import eth_tx_pkg::*;
(
    input  logic [7:0]  data_in,
    input  logic [31:0] state_in,
    output logic [31:0] state_out
);

    function automatic logic [31:0] reflect32(input logic [31:0] v);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    // 0xEDB88320 for the standard polynomial
    localparam logic [31:0] poly_rev = reflect32(crc_poly);

    always_comb begin
        logic [31:0] c;
        c = state_in;
        // lsb first, one shift per data bit
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data_in[i]) begin
                c = (c >> 1) ^ poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        state_out = c;
    end

endmodule

//--- rtl/tx_frame_fifo.sv
// store-and-forward byte FIFO in front of the framer
// a frame shows on the output only once its last byte is stored
module tx_frame_fifo
    import eth_tx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_crc,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,
    input  logic       in_user,
    byte_stream_if.src m
);

    // {user, last, data}
    logic [9:0] mem [2**fifo_addr_w];

    logic [fifo_addr_w-1:0] wr_addr;
    logic [fifo_addr_w-1:0] rd_addr;
    logic [fifo_addr_w:0]   level;
    logic [fifo_addr_w:0]   level_next;
    logic [fifo_addr_w:0]   frame_cnt;
    logic [fifo_addr_w:0]   frame_cnt_next;
    logic [9:0]             rd_word;
    logic                   out_valid;
    logic                   wr_en;
    logic                   rd_en;
    logic                   wr_eof;
    logic                   rd_eof;

    assign wr_en = in_valid && in_ready;
    assign rd_word = mem[rd_addr];
    // complete frames only
    assign out_valid = (frame_cnt != '0);
    assign rd_en = out_valid && m.ready;
    assign wr_eof = wr_en && in_last;
    assign rd_eof = rd_en && rd_word[8];

    assign m.data = rd_word[7:0];
    assign m.last = rd_word[8];
    assign m.user = rd_word[9];
    assign m.valid = out_valid;

    always_comb begin
        level_next = level;
        frame_cnt_next = frame_cnt;
        if (wr_en && !rd_en) begin
            level_next = level + 1'b1;
        end else if (!wr_en && rd_en) begin
            level_next = level - 1'b1;
        end
        if (wr_eof && !rd_eof) begin
            frame_cnt_next = frame_cnt + 1'b1;
        end else if (!wr_eof && rd_eof) begin
            frame_cnt_next = frame_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= {in_user, in_last, in_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            wr_addr <= '0;
            rd_addr <= '0;
            level <= '0;
            frame_cnt <= '0;
            in_ready <= 1'b0;
        end else begin
            if (wr_en) wr_addr <= wr_addr + 1'b1;
            if (rd_en) rd_addr <= rd_addr + 1'b1;
            level <= level_next;
            frame_cnt <= frame_cnt_next;
            // msb of the level is set only when full
            in_ready <= !level_next[fifo_addr_w];
        end
    end

endmodule

//--- rtl/gmii_tx_framer.sv
// GMII frame transmitter: preamble, SFD, payload, padding, FCS, IFG
// expects a whole frame ready at its input once valid rises
module gmii_tx_framer
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        reset_crc,
    byte_stream_if.dst  s,
    input  logic [7:0]  ifg_delay,
    output logic [7:0]  gmii_txd,
    output logic        gmii_tx_en,
    output logic        gmii_tx_er
);

    framer_state_t    state_reg, state_next;
    logic [ptr_w-1:0] frame_ptr_reg, frame_ptr_next;
    logic [ptr_w-1:0] ptr_inc;

    // byte held for the next output cycle, with its flags
    logic [7:0] data_reg, data_next;
    logic       last_reg, last_next;
    logic       user_reg, user_next;

    logic ready_reg, ready_next;
    // draining the rest of an aborted frame
    logic drop_reg, drop_next;

    logic        crc_clear;
    logic        crc_update;
    logic        fetch;
    logic [31:0] crc_state;
    logic [31:0] crc_next;

    logic [7:0] txd_next;
    logic       en_next;
    logic       er_next;

    assign s.ready = ready_reg;

    eth_crc32_byte crc0 (
        .data_in  (data_reg),
        .state_in (crc_state),
        .state_out(crc_next)
    );

    always_comb begin
        state_next = state_reg;
        ptr_inc = frame_ptr_reg + 1'b1;
        frame_ptr_next = frame_ptr_reg;
        data_next = data_reg;
        last_next = last_reg;
        user_next = user_reg;
        ready_next = 1'b0;
        drop_next = drop_reg;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        fetch = 1'b0;
        txd_next = 8'd0;
        en_next = 1'b0;
        er_next = 1'b0;

        case (state_reg)
            state_idle: begin
                crc_clear = 1'b1;
                last_next = 1'b0;
                if (s.valid) begin
                    frame_ptr_next = ptr_w'(1);
                    txd_next = eth_pre;
                    en_next = 1'b1;
                    state_next = state_preamble;
                end
            end
            state_preamble: begin
                crc_clear = 1'b1;
                frame_ptr_next = ptr_inc;
                txd_next = eth_pre;
                en_next = 1'b1;
                if (frame_ptr_reg == ptr_w'(preamble_len - 1)) begin
                    // prefetch first byte while the SFD goes out
                    ready_next = 1'b1;
                end else if (frame_ptr_reg == ptr_w'(preamble_len)) begin
                    txd_next = eth_sfd;
                    frame_ptr_next = '0;
                    fetch = 1'b1;
                end
            end
            state_payload: begin
                crc_update = 1'b1;
                frame_ptr_next = ptr_inc;
                txd_next = data_reg;
                en_next = 1'b1;
                fetch = 1'b1;
            end
            state_last: begin
                crc_update = 1'b1;
                frame_ptr_next = ptr_inc;
                txd_next = data_reg;
                en_next = 1'b1;
                if (user_reg) begin
                    // bad frame, no FCS
                    frame_ptr_next = '0;
                    state_next = state_ifg;
                end else if (frame_ptr_reg < ptr_w'(min_frame_len - 5)) begin
                    data_next = 8'd0;
                    state_next = state_pad;
                end else begin
                    frame_ptr_next = '0;
                    state_next = state_fcs;
                end
            end
            state_pad: begin
                crc_update = 1'b1;
                frame_ptr_next = ptr_inc;
                en_next = 1'b1;
                if (frame_ptr_reg >= ptr_w'(min_frame_len - 5)) begin
                    frame_ptr_next = '0;
                    state_next = state_fcs;
                end
            end
            state_fcs: begin
                frame_ptr_next = ptr_inc;
                en_next = 1'b1;
                // complemented CRC, low byte first
                case (frame_ptr_reg[1:0])
                    2'd0: txd_next = ~crc_state[7:0];
                    2'd1: txd_next = ~crc_state[15:8];
                    2'd2: txd_next = ~crc_state[23:16];
                    2'd3: txd_next = ~crc_state[31:24];
                endcase
                if (frame_ptr_reg[1:0] == 2'd3) begin
                    frame_ptr_next = '0;
                    state_next = state_ifg;
                end
            end
            state_ifg: begin
                crc_clear = 1'b1;
                frame_ptr_next = ptr_inc;
                // error flag on the cycle after a bad frame's last byte
                if (frame_ptr_reg == '0 && last_reg && user_reg) begin
                    er_next = 1'b1;
                end
                if (drop_reg) begin
                    ready_next = 1'b1;
                    if (s.valid && ready_reg && s.last) begin
                        ready_next = 1'b0;
                        drop_next = 1'b0;
                    end
                end
                // at least two idle cycles so tx_er clears before idle
                if (!drop_reg && frame_ptr_reg != '0 && ptr_inc >= ptr_w'(ifg_delay)) begin
                    state_next = state_idle;
                end
            end
            default: state_next = state_idle;
        endcase

        // take the next input byte, or abort when the stream runs dry
        if (fetch) begin
            if (s.valid) begin
                data_next = s.data;
                last_next = s.last;
                user_next = s.user;
                ready_next = !s.last;
                state_next = s.last ? state_last : state_payload;
            end else begin
                er_next = 1'b1;
                frame_ptr_next = '0;
                drop_next = 1'b1;
                ready_next = 1'b1;
                state_next = state_ifg;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state_reg <= state_idle;
            frame_ptr_reg <= '0;
            ready_reg <= 1'b0;
            drop_reg <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_tx_er <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_ptr_reg <= frame_ptr_next;
            ready_reg <= ready_next;
            drop_reg <= drop_next;
            gmii_tx_en <= en_next;
            gmii_tx_er <= er_next;
        end
    end

    always_ff @(posedge clk) begin
        data_reg <= data_next;
        last_reg <= last_next;
        user_reg <= user_next;
        gmii_txd <= txd_next;
        if (crc_clear) begin
            crc_state <= crc_init;
        end else if (crc_update) begin
            crc_state <= crc_next;
        end
    end

endmodule

//--- rtl/gmii_tx_top.sv
// GMII transmit path: frame FIFO feeding the GMII framer
// byte stream in, GMII out, ifg_delay sets the minimum gap
module gmii_tx_top (
    input  logic       clk,
    input  logic       reset_crc,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    input  logic       in_last,
    input  logic       in_user,
    input  logic [7:0] ifg_delay,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    byte_stream_if fr_stream ();

    tx_frame_fifo fifo0 (
        .clk      (clk),
        .reset_crc(reset_crc),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_last  (in_last),
        .in_user  (in_user),
        .m        (fr_stream.src)
    );

    gmii_tx_framer framer0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .s         (fr_stream.dst),
        .ifg_delay (ifg_delay),
        .gmii_txd  (gmii_txd),
        .gmii_tx_en(gmii_tx_en),
        .gmii_tx_er(gmii_tx_er)
    );

endmodule

//--- tb/gmii_tx_checker.sv
// protocol assertions on the GMII framer, bound into every framer instance
// covers tx_er in idle, the inter-frame gap and ready after reset
module gmii_tx_checker
    import eth_tx_pkg::*;
(
    input logic          clk,
    input logic          reset_crc,
    input framer_state_t state,
    input logic          ready,
    input logic [7:0]    ifg_delay,
    input logic          tx_en,
    input logic          tx_er
);

    // idle cycles since tx_en last fell
    logic [15:0] gap_cnt;
    logic        seen_frame;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            gap_cnt <= '0;
            seen_frame <= 1'b0;
        end else if (tx_en) begin
            gap_cnt <= '0;
            seen_frame <= 1'b1;
        end else if (gap_cnt != 16'hFFFF) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    er_idle: assert property (@(posedge clk) disable iff (reset_crc)
        (state == state_idle) |-> !tx_er)
        else $error("tx_er high while the framer is idle");

    ifg_gap: assert property (@(posedge clk) disable iff (reset_crc)
        ($rose(tx_en) && seen_frame) |-> (gap_cnt >= 16'(ifg_delay)))
        else $error("tx_en rose %0d cycles after the last frame", gap_cnt);

    ready_reset: assert property (@(posedge clk) reset_crc |=> !ready)
        else $error("framer ready high right after reset");

endmodule

bind gmii_tx_framer gmii_tx_checker chk0 (
    .clk      (clk),
    .reset_crc(reset_crc),
    .state    (state_reg),
    .ready    (ready_reg),
    .ifg_delay(ifg_delay),
    .tx_en    (gmii_tx_en),
    .tx_er    (gmii_tx_er)
);

//--- tb/gmii_tx_monitor.sv
// GMII monitor that rebuilds each expected frame from its payload and compares
// the testbench queues frames through expect_frame and expect_byte
module gmii_tx_monitor
    import eth_tx_pkg::*;
(
    input  logic       clk,
    input  logic       reset_crc,
    input  logic [7:0] ifg_delay,
    input  logic       in_ready,
    input  logic [7:0] gmii_txd,
    input  logic       gmii_tx_en,
    input  logic       gmii_tx_er,
    output int         pass_cnt,
    output int         fail_cnt
);

    string      exp_name[$];
    int         exp_len[$];
    bit         exp_err[$];
    logic [7:0] exp_data[$];

    logic [7:0] rx_bytes[$];
    bit         in_frame;
    bit         seen_frame;
    bit         er_inside;
    int         gap_len;
    int         gap_at_start;
    bit         gap_short;

    task automatic expect_frame(input string name, input int len, input bit err);
        exp_name.push_back(name);
        exp_len.push_back(len);
        exp_err.push_back(err);
    endtask

    task automatic expect_byte(input logic [7:0] b);
        exp_data.push_back(b);
    endtask

    task automatic check_reset_low(input string sig, input logic v);
        if (v !== 1'b0) begin
            $display("CHECK FAILED reset %s expected 0 actual %b", sig, v);
            fail_cnt++;
        end
    endtask

    // bitwise reflected CRC-32 taken lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic close_frame(input bit er_after);
        logic [7:0]  exp_bytes[$];
        logic [31:0] crc;
        logic [7:0]  b;
        string       name;
        int          len;
        bit          err;
        bit          ok;
        bit          mismatch;
        if (exp_name.size() == 0) begin
            $display("GMII sent a frame of %0d bytes that no test queued", rx_bytes.size());
            fail_cnt++;
            return;
        end
        name = exp_name.pop_front();
        len = exp_len.pop_front();
        err = exp_err.pop_front();
        ok = 1'b1;
        mismatch = 1'b0;
        if (gap_short) begin
            $display("%s started after only %0d idle cycles with ifg_delay %0d",
                     name, gap_at_start, ifg_delay);
            ok = 1'b0;
        end
        for (int i = 0; i < preamble_len; i++) begin
            exp_bytes.push_back(eth_pre);
        end
        exp_bytes.push_back(eth_sfd);
        crc = crc_init;
        for (int i = 0; i < len; i++) begin
            b = exp_data.pop_front();
            exp_bytes.push_back(b);
            crc = crc_step(crc, b);
        end
        // good frames are padded to 60 bytes and carry the FCS
        if (!err) begin
            for (int i = len; i < min_frame_len - 4; i++) begin
                exp_bytes.push_back(8'h00);
                crc = crc_step(crc, 8'h00);
            end
            crc = ~crc;
            for (int i = 0; i < 4; i++) begin
                exp_bytes.push_back(crc[8*i +: 8]);
            end
        end
        if (rx_bytes.size() != exp_bytes.size()) begin
            $display("CHECK FAILED %s frame length expected %0d actual %0d",
                     name, exp_bytes.size(), rx_bytes.size());
            ok = 1'b0;
        end else begin
            foreach (exp_bytes[i]) begin
                if (!mismatch && rx_bytes[i] !== exp_bytes[i]) begin
                    $display("CHECK FAILED %s byte %0d expected %02h actual %02h",
                             name, i, exp_bytes[i], rx_bytes[i]);
                    mismatch = 1'b1;
                    ok = 1'b0;
                end
            end
        end
        if (er_inside) begin
            $display("tx_er went high while %s was being sent", name);
            ok = 1'b0;
        end
        if (er_after != err) begin
            $display("CHECK FAILED %s tx_er after frame expected %0d actual %0d",
                     name, err, er_after);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
            $display("test %s passed", name);
        end else begin
            fail_cnt++;
            $display("test %s failed", name);
        end
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (reset_crc) begin
            in_frame = 1'b0;
            seen_frame = 1'b0;
            gap_len = 0;
            pass_cnt = 0;
            fail_cnt = 0;
            // DUT outputs held low while in reset
            check_reset_low("in_ready", in_ready);
            check_reset_low("gmii_tx_en", gmii_tx_en);
            check_reset_low("gmii_tx_er", gmii_tx_er);
        end else if (gmii_tx_en) begin
            if (!in_frame) begin
                in_frame = 1'b1;
                rx_bytes.delete();
                er_inside = 1'b0;
                gap_at_start = gap_len;
                gap_short = seen_frame && gap_len < int'(ifg_delay);
            end
            rx_bytes.push_back(gmii_txd);
            if (gmii_tx_er) begin
                er_inside = 1'b1;
            end
        end else if (in_frame) begin
            in_frame = 1'b0;
            seen_frame = 1'b1;
            gap_len = 1;
            close_frame(gmii_tx_er);
        end else begin
            gap_len++;
        end
    end

endmodule

//--- tb/gmii_tx_tb.sv
// testbench for the GMII transmit path with frames listed in tb/gmii_tx_input.txt
// drives the input byte stream while gmii_tx_monitor checks what leaves on GMII
module gmii_tx_tb;

    logic       clk;
    logic       reset_crc;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    logic       in_last;
    logic       in_user;
    logic [7:0] ifg_delay;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;

    int     pass_cnt;
    int     fail_cnt;
    integer seed;
    int     limit;
    int     cycle_cnt;
    bit     run_done;

    // one entry per test frame
    string      fr_name[$];
    int         fr_len[$];
    logic [7:0] fr_first[$];
    logic [7:0] fr_step[$];
    int         fr_err[$];
    int         fr_gap[$];

    gmii_tx_top dut0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .in_user   (in_user),
        .ifg_delay (ifg_delay),
        .gmii_txd  (gmii_txd),
        .gmii_tx_en(gmii_tx_en),
        .gmii_tx_er(gmii_tx_er)
    );

    gmii_tx_monitor mon0 (
        .clk       (clk),
        .reset_crc (reset_crc),
        .ifg_delay (ifg_delay),
        .in_ready  (in_ready),
        .gmii_txd  (gmii_txd),
        .gmii_tx_en(gmii_tx_en),
        .gmii_tx_er(gmii_tx_er),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    always #5 clk = ~clk;

    function automatic string vec_to_name(input logic [8*20-1:0] v);
        string s;
        s = "";
        for (int i = 19; i >= 0; i--) begin
            if (v[8*i +: 8] != 8'd0) begin
                s = {s, $sformatf("%c", v[8*i +: 8])};
            end
        end
        return s;
    endfunction

    task automatic load_frames();
        integer           fd;
        int               n;
        int               len;
        int               err;
        int               gap;
        int               total;
        logic [7:0]       first;
        logic [7:0]       step;
        logic [8*128-1:0] line_vec;
        logic [8*20-1:0]  name_vec;
        total = 0;
        fd = $fopen("tb/gmii_tx_input.txt", "r");
        if (fd == 0) begin
            return;
        end
        line_vec = '0;
        while ($fgets(line_vec, fd) != 0) begin
            name_vec = '0;
            n = $sscanf(line_vec, "%s %d %h %h %d %d", name_vec, len, first, step, err, gap);
            // comment and blank lines give fewer than six fields
            if (n == 6) begin
                fr_name.push_back(vec_to_name(name_vec));
                fr_len.push_back(len);
                fr_first.push_back(first);
                fr_step.push_back(step);
                fr_err.push_back(err);
                fr_gap.push_back(gap);
                total += 3 * len + 100 + int'(ifg_delay);
            end
            line_vec = '0;
        end
        $fclose(fd);
        limit = total;
    endtask

    // idle cycles ahead of a byte with a chance of pct percent per cycle
    task automatic insert_gaps(input int pct);
        while (int'($unsigned($random(seed)) % 100) < pct) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_byte(input logic [7:0] d, input bit last, input bit user);
        bit taken;
        taken = 1'b0;
        in_data = d;
        in_valid = 1'b1;
        in_last = last;
        in_user = user;
        while (!taken) begin
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
    endtask

    task automatic send_frame(input int idx);
        logic [7:0] b;
        bit         is_last;
        b = fr_first[idx];
        mon0.expect_frame(fr_name[idx], fr_len[idx], fr_err[idx] != 0);
        for (int j = 0; j < fr_len[idx]; j++) begin
            is_last = (j == fr_len[idx] - 1);
            mon0.expect_byte(b);
            insert_gaps(fr_gap[idx]);
            send_byte(b, is_last, is_last && fr_err[idx] != 0);
            b = b + fr_step[idx];
        end
    endtask

    initial begin
        clk = 1'b0;
        reset_crc = 1'b1;
        in_data = 8'd0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_user = 1'b0;
        ifg_delay = 8'd12;
        seed = 32'hf6f119d2;
        run_done = 1'b0;
        limit = 0;
        load_frames();
        if (fr_len.size() == 0) begin
            $display("no test frames could be read from tb/gmii_tx_input.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset_crc = 1'b0;
            foreach (fr_len[i]) begin
                send_frame(i);
            end
            while (pass_cnt + fail_cnt < fr_len.size()) begin
                @(negedge clk);
            end
            run_done = 1'b1;
            // room for the checker to see the last gap
            repeat (2 * int'(ifg_delay)) @(negedge clk);
            $display("frames %0d, passed %0d, failed %0d", fr_len.size(), pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt == fr_len.size()) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

    // limit grows with the frame lengths read from the file
    initial begin
        cycle_cnt = 0;
        wait (limit > 0);
        while (!run_done && cycle_cnt < limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        if (!run_done) begin
            $display("run timed out after %0d cycles before all frames came out", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

//--- tb/gmii_tx_input.txt
# name length first_byte(hex) step(hex) error_flag gap_percent
# payload byte k is first_byte + k * step, error_flag sets user on the last byte
short20 20 01 01 0 0
long200 200 10 03 0 0
error30 30 a0 01 1 0
gapped80 80 33 05 0 60
b2b_a 64 00 01 0 0
b2b_b 46 ff fd 0 0
b2b_c 100 5a 11 0 0
exact60 60 40 07 0 0
gapped_err 25 77 02 1 40

//--- sources.f
rtl/eth_tx_pkg.sv
rtl/byte_stream_if.sv
rtl/eth_crc32_byte.sv
rtl/tx_frame_fifo.sv
rtl/gmii_tx_framer.sv
rtl/gmii_tx_top.sv
tb/gmii_tx_checker.sv
tb/gmii_tx_monitor.sv
tb/gmii_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the GMII transmit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module gmii_tx_tb -f sources.f -o gmii_tx_sim
./obj_dir/gmii_tx_sim | tee sim.log
if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
